// File: eeprom_wr.f
source/i2c_pkg.sv
source/eeprom_pkg.sv
source/scl_timer.sv
source/byte_shifter.sv
source/eeprom_ctrl_fsm.sv
source/eeprom_wr.sv
sim/eeprom_model.sv
sim/eeprom_wr_sva.sv
sim/eeprom_wr_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the eeprom controller testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module eeprom_wr_tb \
    -f eeprom_wr.f \
    -o eeprom_wr_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/eeprom_wr_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST PASSED"; then
    exit 0
fi
exit 1

// File: sim/eeprom_wr_tb.sv
module eeprom_wr_tb;
    import eeprom_pkg::*;

    localparam int ack_limit = 400 * 8; // 400 scl periods

    logic      CLK = 1'b0;
    logic      RESET;
    logic      wr;
    logic      rd;
    mem_addr_t addr;
    mem_data_t wr_data;
    mem_data_t rd_data;
    logic      ack;
    logic      nack_err;
    logic      busy;
    logic      scl;
    logic      sda_out;
    logic      sda_oe;
    logic      sda_in;
    logic      slave_pull;
    logic      ack_off;

    mem_data_t ref_mem [mem_addr_t];
    mem_addr_t used_addr [$];
    int        errors    = 0;
    int        timeouts  = 0;
    int        ack_count = 0;
    logic      last_nack;
    mem_data_t last_rd;

    assign sda_in = !((sda_oe && !sda_out) || slave_pull); // open drain line

    eeprom_wr u_eeprom_wr (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wr_data  (wr_data),
        .rd_data  (rd_data),
        .ack      (ack),
        .nack_err (nack_err),
        .busy     (busy),
        .scl      (scl),
        .sda_out  (sda_out),
        .sda_oe   (sda_oe),
        .sda_in   (sda_in)
    );

    eeprom_model u_eeprom_model (
        .scl      (scl),
        .sda      (sda_in),
        .ack_off  (ack_off),
        .pull_low (slave_pull)
    );

    always #4 CLK = ~CLK;

    always @(negedge CLK) begin
        if (ack) begin
            ack_count++;
        end
    end

    task automatic check_value(input string what, input int actual, input int expected);
        if (actual != expected) begin
            errors++;
            $display("Fail at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    function automatic mem_data_t expected_data(input mem_addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : 8'hff;
    endfunction

    task automatic wait_for_busy(input logic level);
        int cycles;
        cycles = 0;
        while ((busy !== level) && (cycles < 64)) begin
            @(negedge CLK);
            cycles++;
        end
        if (busy !== level) begin
            timeouts++;
            $display("timeout at %0t: busy did not reach %0b within 64 cycles", $time, level);
        end
    endtask

    task automatic wait_for_ack();
        int cycles;
        cycles = 0;
        @(negedge CLK);
        while ((ack !== 1'b1) && (cycles < ack_limit)) begin
            @(negedge CLK);
            cycles++;
        end
        if (ack !== 1'b1) begin
            timeouts++;
            $display("timeout at %0t: no ack within 400 scl periods", $time);
        end
        last_nack = nack_err;
        last_rd   = rd_data;
    endtask

    task automatic issue_request(input logic is_wr, input mem_addr_t a, input mem_data_t d);
        @(posedge CLK);
        wr      <= is_wr;
        rd      <= !is_wr;
        addr    <= a;
        wr_data <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic write_byte(input mem_addr_t a, input mem_data_t d, input logic nack_expected);
        wait_for_busy(1'b0);
        issue_request(1'b1, a, d);
        wait_for_ack();
        check_value($sformatf("nack_err of write to %03h", a), int'(last_nack),
                    int'(nack_expected));
        if (!nack_expected) begin
            ref_mem[a] = d;
            used_addr.push_back(a);
        end
    endtask

    task automatic read_byte(input mem_addr_t a);
        wait_for_busy(1'b0);
        issue_request(1'b0, a, 8'h00);
        wait_for_ack();
        check_value($sformatf("nack_err of read from %03h", a), int'(last_nack), 0);
        check_value($sformatf("rd_data from %03h", a), int'(last_rd), int'(expected_data(a)));
    endtask

    initial begin
        mem_addr_t a;
        mem_data_t d;
        mem_data_t low;
        int        acks_before;
        RESET   <= 1'b1;
        wr      <= 1'b0;
        rd      <= 1'b0;
        addr    <= '0;
        wr_data <= '0;
        ack_off <= 1'b0;
        void'($urandom(69833));
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);

        check_value("busy after reset", int'(busy), 0);
        check_value("ack after reset", int'(ack), 0);
        check_value("nack_err after reset", int'(nack_err), 0);
        check_value("scl after reset", int'(scl), 1);
        check_value("sda_oe after reset", int'(sda_oe), 0);

        a = mem_addr_t'($urandom);
        write_byte(a, mem_data_t'($urandom), 1'b0);
        read_byte(a);

        // same low byte in all eight blocks
        low = mem_data_t'($urandom);
        for (int hi = 0; hi < 8; hi++) begin
            write_byte({3'(hi), low}, mem_data_t'($urandom), 1'b0);
        end
        for (int hi = 0; hi < 8; hi++) begin
            read_byte({3'(hi), low});
        end
        for (int n = 0; n < 44; n++) begin
            if (($urandom_range(1) == 0) || (used_addr.size() == 0)) begin
                a = mem_addr_t'($urandom);
            end else begin
                a = used_addr[$urandom_range(used_addr.size() - 1)];
            end
            if ($urandom_range(1) == 1) begin
                write_byte(a, mem_data_t'($urandom), 1'b0);
            end else begin
                read_byte(a);
            end
        end

        // write must fail and leave memory alone while the slave is silent
        a = mem_addr_t'($urandom);
        d = expected_data(a) ^ 8'h5a;
        @(posedge CLK);
        ack_off <= 1'b1;
        write_byte(a, d, 1'b1);
        @(posedge CLK);
        ack_off <= 1'b0;
        read_byte(a);

        // strobes while busy are dropped
        a = mem_addr_t'($urandom);
        d = mem_data_t'($urandom);
        wait_for_busy(1'b0);
        acks_before = ack_count;
        issue_request(1'b1, a, d);
        wait_for_busy(1'b1);
        issue_request(1'b1, a, ~d);
        issue_request(1'b0, a, 8'h00);
        wait_for_ack();
        check_value("nack_err of first request", int'(last_nack), 0);
        ref_mem[a] = d;
        used_addr.push_back(a);
        repeat (64 * 8) @(negedge CLK); // two write lengths of quiet bus
        check_value("acks for overlapping requests", ack_count - acks_before, 1);
        check_value("busy after overlapping requests", int'(busy), 0);
        read_byte(a);

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: sim/eeprom_wr_sva.sv
module eeprom_wr_sva (
    input logic CLK,
    input logic RESET,
    input logic scl,
    input logic sda_in,
    input logic tick_high_mid,
    input logic ack,
    input logic nack_err
);

    // only start and stop move sda with scl high, right after the high-mid tick
    assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (sda_in != $past(sda_in))) |-> $past(tick_high_mid))
        else $error("sda changed while scl was high outside a start or stop");

    assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
        else $error("ack lasted longer than one cycle");

    assert property (@(posedge CLK) disable iff (RESET) nack_err |=> !nack_err)
        else $error("nack_err lasted longer than one cycle");

    assert property (@(posedge CLK) disable iff (RESET) nack_err |-> ack)
        else $error("nack_err without ack");

endmodule

bind eeprom_wr eeprom_wr_sva u_eeprom_wr_sva (
    .CLK           (CLK),
    .RESET         (RESET),
    .scl           (scl),
    .sda_in        (sda_in),
    .tick_high_mid (tick_high_mid),
    .ack           (ack),
    .nack_err      (nack_err)
);

// File: sim/eeprom_model.sv
module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic ack_off,
    output logic pull_low
);
    logic [7:0]  mem [0:2047];
    logic        scl_q     = 1'b1;
    logic        sda_q     = 1'b1;
    logic        active    = 1'b0;
    logic        sending   = 1'b0;
    logic        read_req  = 1'b0;
    logic        drive_low = 1'b0;
    logic [3:0]  slot      = 4'd0;
    logic [7:0]  shreg     = 8'd0;
    logic [7:0]  tx        = 8'd0;
    logic [10:0] ptr       = 11'd0;
    int          byte_num  = 0;

    assign pull_low = drive_low;

    initial begin
        for (int i = 0; i < 2048; i++) begin
            mem[11'(i)] = 8'hff; // erased device
        end
    end

    always @(posedge scl or negedge scl or posedge sda or negedge sda) begin
        if (scl && scl_q && sda_q && !sda) begin
            active   = 1'b1; // start or repeated start
            sending  = 1'b0;
            read_req = 1'b0;
            slot     = 4'd0;
            byte_num = 0;
        end else if (scl && scl_q && !sda_q && sda) begin
            active    = 1'b0; // stop
            sending   = 1'b0;
            drive_low <= 1'b0;
        end else if (active && scl && !scl_q) begin
            if (slot < 4'd8) begin
                if (!sending) begin
                    shreg = {shreg[6:0], sda};
                end
                slot = slot + 4'd1;
            end else begin
                slot = 4'd0;
                if (sending) begin
                    sending = 1'b0; // single byte reads only, master nacks
                end else if (read_req) begin
                    read_req = 1'b0;
                    sending  = 1'b1;
                    tx       = mem[ptr];
                end
            end
        end else if (active && !scl && scl_q) begin
            if (slot == 4'd8) begin
                if (sending || ack_off || (byte_num == 0 && shreg[7:4] != 4'b1010)) begin
                    drive_low <= 1'b0;
                end else begin
                    drive_low <= 1'b1;
                    if (byte_num == 0) begin
                        ptr      = {shreg[3:1], ptr[7:0]}; // block bits
                        read_req = shreg[0];
                    end else if (byte_num == 1) begin
                        ptr[7:0] = shreg;
                    end else begin
                        mem[ptr] = shreg;
                        ptr      = ptr + 11'd1;
                    end
                    byte_num++;
                end
            end else if (sending) begin
                drive_low <= !tx[7];
                tx = {tx[6:0], 1'b0};
            end else begin
                drive_low <= 1'b0;
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// File: source/eeprom_wr.sv
module eeprom_wr (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  eeprom_pkg::mem_addr_t addr,
    input  eeprom_pkg::mem_data_t wr_data,
    output eeprom_pkg::mem_data_t rd_data,
    output logic                  ack,
    output logic                  nack_err,
    output logic                  busy,
    output logic                  scl,
    output logic                  sda_out,
    output logic                  sda_oe,
    input  logic                  sda_in
);
    import eeprom_pkg::*;

    logic       run;
    logic       tick_low_mid;
    logic       tick_high_mid;
    logic       tick_period_end;
    logic       step_done;
    logic       ack_seen;
    shift_cmd_t cmd;
    mem_data_t  tx_byte;
    mem_data_t  rx_byte;

    scl_timer u_scl_timer (
        .CLK             (CLK),
        .RESET           (RESET),
        .run             (run),
        .scl             (scl),
        .tick_low_mid    (tick_low_mid),
        .tick_high_mid   (tick_high_mid),
        .tick_period_end (tick_period_end)
    );

    byte_shifter u_byte_shifter (
        .CLK             (CLK),
        .RESET           (RESET),
        .tick_low_mid    (tick_low_mid),
        .tick_high_mid   (tick_high_mid),
        .tick_period_end (tick_period_end),
        .cmd             (cmd),
        .tx_byte         (tx_byte),
        .sda_in          (sda_in),
        .sda_out         (sda_out),
        .sda_oe          (sda_oe),
        .rx_byte         (rx_byte),
        .ack_seen        (ack_seen),
        .step_done       (step_done)
    );

    eeprom_ctrl_fsm u_eeprom_ctrl_fsm (
        .CLK             (CLK),
        .RESET           (RESET),
        .wr              (wr),
        .rd              (rd),
        .addr            (addr),
        .wr_data         (wr_data),
        .tick_period_end (tick_period_end),
        .step_done       (step_done),
        .ack_seen        (ack_seen),
        .rx_byte         (rx_byte),
        .run             (run),
        .cmd             (cmd),
        .tx_byte         (tx_byte),
        .rd_data         (rd_data),
        .ack             (ack),
        .nack_err        (nack_err),
        .busy            (busy)
    );

endmodule

// File: source/eeprom_ctrl_fsm.sv
module eeprom_ctrl_fsm (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   wr,
    input  logic                   rd,
    input  eeprom_pkg::mem_addr_t  addr,
    input  eeprom_pkg::mem_data_t  wr_data,
    input  logic                   tick_period_end,
    input  logic                   step_done,
    input  logic                   ack_seen,
    input  eeprom_pkg::mem_data_t  rx_byte,
    output logic                   run,
    output eeprom_pkg::shift_cmd_t cmd,
    output eeprom_pkg::mem_data_t  tx_byte,
    output eeprom_pkg::mem_data_t  rd_data,
    output logic                   ack,
    output logic                   nack_err,
    output logic                   busy
);
    import i2c_pkg::*;
    import eeprom_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    shift_cmd_t  next_cmd;
    mem_data_t   next_tx;
    logic        accept;
    logic        is_read;
    logic        err;
    logic        sent_byte;
    logic        slave_nack;
    mem_addr_t   addr_q;
    mem_data_t   data_q;
    mem_data_t   ctrl_wr_byte;
    mem_data_t   ctrl_rd_byte;
    bit_cnt_t    rx_bits;

    // ack cycle still counts as busy, so no request is taken then
    assign accept = (state == idle) && !ack && (wr || rd);

    assign ctrl_wr_byte = {device_code, addr_q[10:8], rw_write};
    assign ctrl_rd_byte = {device_code, addr_q[10:8], rw_read};

    assign sent_byte = (state == ctrl_write) || (state == addr_write)
                    || (state == data_write) || (state == ctrl_read);
    assign slave_nack = sent_byte && step_done && !ack_seen;

    // what follows the step that just finished
    always_comb begin
        next_state = state;
        next_cmd   = none;
        next_tx    = tx_byte;
        case (state)
            start: begin
                next_state = ctrl_write;
                next_cmd   = send_byte;
                next_tx    = ctrl_wr_byte;
            end
            ctrl_write: begin
                next_state = addr_write;
                next_cmd   = send_byte;
                next_tx    = addr_q[7:0];
            end
            addr_write: begin
                if (is_read) begin
                    next_state = restart;
                    next_cmd   = send_start;
                end else begin
                    next_state = data_write;
                    next_cmd   = send_byte;
                    next_tx    = data_q;
                end
            end
            data_write: begin
                next_state = stop;
                next_cmd   = send_stop;
            end
            restart: begin
                next_state = ctrl_read;
                next_cmd   = send_byte;
                next_tx    = ctrl_rd_byte;
            end
            ctrl_read: begin
                next_state = data_read;
                next_cmd   = recv_byte;
            end
            master_nack: begin
                next_state = stop;
                next_cmd   = send_stop;
            end
            stop: begin
                next_state = done;
            end
            default: begin
                next_state = state;
            end
        endcase
        // abandon the transfer when the slave does not ack
        if (slave_nack) begin
            next_state = stop;
            next_cmd   = send_stop;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= idle;
            run      <= 1'b0;
            cmd      <= none;
            ack      <= 1'b0;
            nack_err <= 1'b0;
            busy     <= 1'b0;
            err      <= 1'b0;
            is_read  <= 1'b0;
            rx_bits  <= '0;
        end else begin
            cmd      <= none; // one cycle per step
            ack      <= 1'b0;
            nack_err <= 1'b0;
            case (state)
                idle: begin
                    if (ack) begin
                        busy <= 1'b0;
                    end else if (accept) begin
                        is_read <= !wr; // wr wins
                        err     <= 1'b0;
                        busy    <= 1'b1;
                        run     <= 1'b1;
                        cmd     <= send_start;
                        state   <= start;
                    end
                end
                data_read: begin
                    if (tick_period_end) begin
                        rx_bits <= rx_bits + 1'b1;
                        if (rx_bits == last_data_bit) begin
                            state <= master_nack;
                        end
                    end
                end
                done: begin
                    ack      <= 1'b1;
                    nack_err <= err;
                    state    <= idle;
                end
                default: begin
                    if (step_done) begin
                        state   <= next_state;
                        cmd     <= next_cmd;
                        rx_bits <= '0;
                        if (slave_nack) begin
                            err <= 1'b1;
                        end
                        if (state == stop) begin
                            run <= 1'b0;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == idle) begin
            addr_q <= addr;
            data_q <= wr_data;
        end
        if (step_done) begin
            tx_byte <= next_tx;
        end
        if ((state == done) && is_read && !err) begin
            rd_data <= rx_byte;
        end
    end

endmodule

// File: source/byte_shifter.sv
module byte_shifter (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   tick_low_mid,
    input  logic                   tick_high_mid,
    input  logic                   tick_period_end,
    input  eeprom_pkg::shift_cmd_t cmd,
    input  eeprom_pkg::mem_data_t  tx_byte,
    input  logic                   sda_in,
    output logic                   sda_out,
    output logic                   sda_oe,
    output eeprom_pkg::mem_data_t  rx_byte,
    output logic                   ack_seen,
    output logic                   step_done
);
    import i2c_pkg::*;
    import eeprom_pkg::*;

    shift_cmd_t mode;
    bit_cnt_t   bit_cnt;
    mem_data_t  sr;
    logic       last_slot;

    // start and stop are single period steps
    assign last_slot = (mode == send_start) || (mode == send_stop) || (bit_cnt == ack_slot);
    assign step_done = (mode != none) && tick_period_end && last_slot;
    assign rx_byte   = sr;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            mode     <= none;
            bit_cnt  <= '0;
            sda_out  <= 1'b1;
            sda_oe   <= 1'b0;
            ack_seen <= 1'b0;
        end else if (mode == none) begin
            if (cmd != none) begin
                mode     <= cmd;
                bit_cnt  <= '0;
                ack_seen <= 1'b0;
            end
        end else begin
            if (tick_period_end) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (last_slot) begin
                    mode <= none;
                end
            end
            case (mode)
                send_start: begin
                    if (tick_low_mid) begin
                        sda_oe  <= 1'b0; // let the line float high
                        sda_out <= 1'b1;
                    end
                    if (tick_high_mid) begin
                        sda_oe  <= 1'b1; // falling sda with scl high
                        sda_out <= 1'b0;
                    end
                end
                send_stop: begin
                    if (tick_low_mid) begin
                        sda_oe  <= 1'b1;
                        sda_out <= 1'b0;
                    end
                    if (tick_high_mid) begin
                        sda_oe  <= 1'b0; // rising sda with scl high
                        sda_out <= 1'b1;
                    end
                end
                send_byte: begin
                    if (tick_low_mid) begin
                        sda_oe  <= (bit_cnt != ack_slot); // slave owns the ack slot
                        sda_out <= (bit_cnt == ack_slot) ? 1'b1 : sr[7];
                    end
                    if (tick_high_mid && (bit_cnt == ack_slot)) begin
                        ack_seen <= !sda_in;
                    end
                end
                recv_byte: begin
                    if (tick_low_mid) begin
                        sda_out <= 1'b1;
                        sda_oe  <= (bit_cnt == ack_slot); // single byte read so always nack
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if ((mode == none) && (cmd == send_byte)) begin
            sr <= tx_byte;
        end else if ((mode == send_byte) && tick_low_mid && (bit_cnt < ack_slot)) begin
            sr <= {sr[6:0], 1'b0};
        end else if ((mode == recv_byte) && tick_high_mid && (bit_cnt < ack_slot)) begin
            sr <= {sr[6:0], sda_in};
        end
    end

endmodule

// File: source/scl_timer.sv
module scl_timer (
    input  logic CLK,
    input  logic RESET,
    input  logic run,
    output logic scl,
    output logic tick_low_mid,
    output logic tick_high_mid,
    output logic tick_period_end
);
    import i2c_pkg::*;

    quarter_cnt_t q_cnt;
    scl_phase_t   phase;
    scl_phase_t   next_phase;
    logic         q_end;

    assign q_end = run && (q_cnt == quarter_last);

    always_comb begin
        case (phase)
            low_first: next_phase = rise;
            rise:      next_phase = high;
            high:      next_phase = fall;
            default:   next_phase = low_first;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            q_cnt <= '0;
            phase <= low_first;
        end else if (!run) begin
            // parked so the first period after run is full length
            q_cnt <= '0;
            phase <= low_first;
        end else if (q_end) begin
            q_cnt <= '0;
            phase <= next_phase;
        end else begin
            q_cnt <= q_cnt + 1'b1;
        end
    end

    // bus clock idles high between transactions
    assign scl = !run || (phase == high) || (phase == fall);

    assign tick_low_mid    = q_end && (phase == low_first);
    assign tick_high_mid   = q_end && (phase == high);
    assign tick_period_end = q_end && (phase == fall);

endmodule

// File: source/eeprom_pkg.sv
package eeprom_pkg;

    // 2k byte device
    localparam int addr_w    = 11;
    localparam int data_w    = 8;
    localparam int mem_bytes = 1 << addr_w;

    typedef logic [addr_w-1:0] mem_addr_t;
    typedef logic [data_w-1:0] mem_data_t;

    // control byte is {device_code, a10..a8, r/w}
    localparam logic [3:0] device_code = 4'b1010;
    localparam logic       rw_write    = 1'b0;
    localparam logic       rw_read     = 1'b1;

    typedef enum logic [3:0] {
        idle,
        start,
        ctrl_write,
        addr_write,
        data_write,
        restart,
        ctrl_read,
        data_read,
        master_nack,
        stop,
        done
    } ctrl_state_t;

    typedef enum logic [2:0] {
        none,
        send_start,
        send_byte,
        recv_byte,
        send_stop
    } shift_cmd_t;

endpackage

// File: source/i2c_pkg.sv
package i2c_pkg;

    // one scl period is four quarters of quarter_cycles clocks each
    localparam int quarter_cycles = 2;
    localparam int quarter_cnt_w  = (quarter_cycles > 1) ? $clog2(quarter_cycles) : 1;

    typedef logic [quarter_cnt_w-1:0] quarter_cnt_t;

    localparam quarter_cnt_t quarter_last = quarter_cnt_t'(quarter_cycles - 1);

    // scl is low in the first two quarters, high in the last two
    typedef enum logic [1:0] {
        low_first = 2'd0,
        rise      = 2'd1,
        high      = 2'd2,
        fall      = 2'd3
    } scl_phase_t;

    // slots 0..7 carry data bits msb first, slot 8 is the ack
    typedef logic [3:0] bit_cnt_t;

    localparam bit_cnt_t last_data_bit = 4'd7;
    localparam bit_cnt_t ack_slot      = 4'd8;

endpackage
